// File: Makefile
# Verilator flow for the uspispy testbench

LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module uspispy_tb -f uspispy.f

sim:
	verilator --binary --timing --top-module uspispy_tb -f uspispy.f -Mdir obj_dir -o uspispy_sim
	./obj_dir/uspispy_sim | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: bench/psram_model.sv
`timescale 1ns/1ns

module psram_model #(
	parameter int chip_idx = 0
) (
	input  logic clk,
	input  logic cs,
	input  logic mosi,
	output logic miso
);

	// edges seen since chip select fell
	logic [15:0] cnt;
	// command byte and three address bytes, msb first
	logic [31:0] in_sr;
	// position inside the data phase
	logic [15:0] rel;
	logic [23:0] cur_addr;
	logic [7:0]  cur_byte;

	always @(posedge clk or posedge cs) begin
		if (cs) begin
			cnt   <= 16'd0;
			in_sr <= 32'd0;
		end else begin
			cnt <= cnt + 16'd1;
			// header only, data phase ignores mosi
			if (cnt < 16'd32)
				in_sr <= {in_sr[30:0], mosi};
		end
	end

	// data starts right after edge 32, address advances every byte
	assign rel      = cnt - 16'd32;
	assign cur_addr = in_sr[23:0] + {13'd0, rel[13:3]};
	// pattern: low address byte, chip 1 inverted
	assign cur_byte = cur_addr[7:0] ^ 8'h5A ^ ((chip_idx != 0) ? 8'hFF : 8'h00);

	// only the read command gets an answer
	assign miso = (!cs && cnt >= 16'd32 && in_sr[31:24] == 8'h03) ?
		cur_byte[~rel[2:0]] : 1'b0;

endmodule

// File: bench/uspispy_tb.sv
`timescale 1ns/1ns

module uspispy_tb;

	localparam int clk_period = 40;
	// read id, status, two reads, two programs, wren, wrds, erase
	localparam int n_txn = 9;

	logic        clk;
	logic        spi_cs_in;
	logic        mosi;
	logic        miso;
	logic [7:0]  sr_in;
	logic        ram0_cs;
	logic        ram1_cs;
	logic        ram_mosi;
	logic        ram0_miso;
	logic        ram1_miso;
	logic        log_req;
	logic        log_ack;
	logic [7:0]  log_cmd;
	logic [23:0] log_addr;
	logic [7:0]  buf_raddr;
	logic [7:0]  buf_rdata;

	// host side transaction bytes
	logic [7:0]  tx_buf [16];
	logic [7:0]  rx_buf [16];
	// what the page buffer should hold
	logic [7:0]  page_ref [8];

	// controller model state
	int          log_reqs;
	int          log_done;
	logic [7:0]  cap_cmd;
	logic [23:0] cap_addr;

	logic [31:0] rng = 32'd95;

	uspispy #(
		.page_abits (8)
	) uut (
		.clk       (clk),
		.spi_cs_in (spi_cs_in),
		.mosi      (mosi),
		.miso      (miso),
		.sr_in     (sr_in),
		.ram0_cs   (ram0_cs),
		.ram1_cs   (ram1_cs),
		.ram_mosi  (ram_mosi),
		.ram0_miso (ram0_miso),
		.ram1_miso (ram1_miso),
		.log_req   (log_req),
		.log_ack   (log_ack),
		.log_cmd   (log_cmd),
		.log_addr  (log_addr),
		.buf_raddr (buf_raddr),
		.buf_rdata (buf_rdata)
	);

	psram_model #(.chip_idx(0)) ram0 (
		.clk  (clk),
		.cs   (ram0_cs),
		.mosi (ram_mosi),
		.miso (ram0_miso)
	);

	psram_model #(.chip_idx(1)) ram1 (
		.clk  (clk),
		.cs   (ram1_cs),
		.mosi (ram_mosi),
		.miso (ram1_miso)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// lcg with the output folded so low bits are usable
	function automatic logic [31:0] lcg_rand();
		rng = rng * 32'd1103515245 + 32'd12345;
		return rng ^ (rng >> 15);
	endfunction

	// expected psram data for a chip at an address
	function automatic logic [7:0] psram_byte(input logic chip, input logic [23:0] addr);
		return addr[7:0] ^ 8'h5A ^ (chip ? 8'hFF : 8'h00);
	endfunction

	task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("FAILED %s: expected %0h, actual %0h", name, exp, act);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	// one chip select pulse with bits driven on the rising edge and miso read on the falling edge
	task automatic run_txn(input string name, input int n, input int logs);
		int         base_req;
		int         base_done;
		int         i;
		int         b;
		logic [7:0] r;
		base_req  = log_reqs;
		base_done = log_done;
		for (i = 0; i < n; i++) begin
			for (b = 7; b >= 0; b--) begin
				@(posedge clk);
				spi_cs_in <= 1'b0;
				mosi      <= tx_buf[i][b];
				@(negedge clk);
				r[b] = miso;
				// psrams hear the host bit as sent
				check_eq({name, " ram_mosi"}, 32'(tx_buf[i][b]), 32'(ram_mosi));
			end
			rx_buf[i] = r;
			// both chips listen to the command byte
			if (i == 0) begin
				check_eq({name, " ram0_cs on command"}, 32'd0, 32'(ram0_cs));
				check_eq({name, " ram1_cs on command"}, 32'd0, 32'(ram1_cs));
			end
			// only a read keeps them selected
			if (i == 1) begin
				check_eq({name, " ram0_cs after command"}, 32'(tx_buf[0] != 8'h03),
					32'(ram0_cs));
				check_eq({name, " ram1_cs after command"}, 32'(tx_buf[0] != 8'h03),
					32'(ram1_cs));
			end
		end
		// keep the transaction open until the controller has finished its exchange
		while (log_done < base_done + logs) begin
			@(posedge clk);
			mosi <= 1'b0;
		end
		@(posedge clk);
		spi_cs_in <= 1'b1;
		mosi      <= 1'b0;
		repeat (2) @(posedge clk);
		check_eq({name, " log requests"}, 32'(logs), 32'(log_reqs - base_req));
	endtask

	task automatic read_id();
		tx_buf[0] = 8'h9F;
		tx_buf[1] = 8'h00;
		tx_buf[2] = 8'h00;
		tx_buf[3] = 8'h00;
		run_txn("read id", 4, 0);
		check_eq("read id byte 0", 32'h00C2, 32'(rx_buf[1]));
		check_eq("read id byte 1", 32'h0020, 32'(rx_buf[2]));
		check_eq("read id byte 2", 32'h0018, 32'(rx_buf[3]));
	endtask

	task automatic read_status();
		logic [31:0] v;
		v = lcg_rand();
		@(posedge clk);
		sr_in <= v[7:0];
		tx_buf[0] = 8'h05;
		tx_buf[1] = 8'h00;
		tx_buf[2] = 8'h00;
		run_txn("read status", 3, 0);
		// status is sent again for every extra byte
		check_eq("read status first", 32'(v[7:0]), 32'(rx_buf[1]));
		check_eq("read status repeat", 32'(v[7:0]), 32'(rx_buf[2]));
	endtask

	task automatic read_flash(input logic hi);
		logic [31:0] v;
		logic [23:0] addr;
		int          k;
		v    = lcg_rand();
		addr = {hi, v[22:0]};
		tx_buf[0] = 8'h03;
		tx_buf[1] = addr[23:16];
		tx_buf[2] = addr[15:8];
		tx_buf[3] = addr[7:0];
		for (k = 4; k < 8; k++)
			tx_buf[k] = 8'h00;
		run_txn("read", 8, 1);
		for (k = 0; k < 4; k++)
			check_eq($sformatf("read chip %0d byte %0d", hi, k),
				32'(psram_byte(hi, addr + 24'(k))), 32'(rx_buf[4 + k]));
		check_eq("read log cmd", 32'h0003, 32'(cap_cmd));
		check_eq("read log addr", 32'(addr), 32'(cap_addr));
	endtask

	task automatic verify_page(input string name);
		int k;
		for (k = 0; k < 8; k++) begin
			@(posedge clk);
			buf_raddr <= 8'(k);
			@(negedge clk);
			check_eq($sformatf("%s buffer %0d", name, k), 32'(page_ref[k]), 32'(buf_rdata));
		end
	endtask

	// program with wel clear must leave the buffer alone
	task automatic program_page(input logic wel);
		logic [31:0] v;
		logic [7:0]  sr;
		logic [23:0] addr;
		int          k;
		v      = lcg_rand();
		sr     = v[7:0];
		sr[1]  = wel;
		v      = lcg_rand();
		addr   = v[23:0];
		@(posedge clk);
		sr_in <= sr;
		tx_buf[0] = 8'h02;
		tx_buf[1] = addr[23:16];
		tx_buf[2] = addr[15:8];
		tx_buf[3] = addr[7:0];
		for (k = 0; k < 8; k++) begin
			v = lcg_rand();
			tx_buf[4 + k] = v[7:0];
			if (wel)
				page_ref[k] = v[7:0];
		end
		run_txn("page program", 12, 1);
		check_eq("page program log cmd", 32'h0002, 32'(cap_cmd));
		check_eq("page program log addr", 32'(addr), 32'(cap_addr));
		verify_page(wel ? "program wel set" : "program wel clear");
	endtask

	task automatic simple_cmd(input logic [7:0] cmd, input string name);
		tx_buf[0] = cmd;
		tx_buf[1] = 8'h00;
		run_txn(name, 2, 1);
		check_eq({name, " log cmd"}, 32'(cmd), 32'(cap_cmd));
	endtask

	task automatic erase_sector();
		logic [31:0] v;
		logic [23:0] addr;
		v    = lcg_rand();
		addr = v[23:0];
		tx_buf[0] = 8'h20;
		tx_buf[1] = addr[23:16];
		tx_buf[2] = addr[15:8];
		tx_buf[3] = addr[7:0];
		run_txn("erase", 4, 1);
		check_eq("erase log cmd", 32'h0020, 32'(cap_cmd));
		check_eq("erase log addr", 32'(addr), 32'(cap_addr));
	endtask

	// controller side of the log where ack follows req in four phases
	initial begin
		log_ack  = 1'b0;
		log_reqs = 0;
		log_done = 0;
		forever begin
			@(posedge clk);
			if (log_req && !log_ack) begin
				log_ack  <= 1'b1;
				cap_cmd  <= log_cmd;
				cap_addr <= log_addr;
				log_reqs <= log_reqs + 1;
			end else if (!log_req && log_ack) begin
				log_ack  <= 1'b0;
				log_done <= log_done + 1;
			end
		end
	end

	// roughly 80 cycles per transaction is plenty
	initial begin
		#(n_txn * 80 * clk_period);
		$display("watchdog expired before all transactions completed");
		$display("sim failed");
		$fatal(1);
	end

	initial begin
		spi_cs_in = 1'b1;
		mosi      = 1'b0;
		sr_in     = 8'h00;
		buf_raddr = 8'h00;
		// chip select high doubles as reset
		repeat (2) @(posedge clk);
		read_id();
		read_status();
		read_flash(1'b0);
		read_flash(1'b1);
		program_page(1'b1);
		program_page(1'b0);
		simple_cmd(8'h06, "wren");
		simple_cmd(8'h04, "wrds");
		erase_sector();
		$display("sim passed");
		$finish;
	end

endmodule

// File: uspispy.f
verilog/uspispy_pkg.sv
verilog/spi_frame_if.sv
verilog/spi_shifter.sv
verilog/spi_byte_counter.sv
verilog/spi_cmd_fsm.sv
verilog/page_buffer.sv
verilog/cmd_logger.sv
verilog/psram_router.sv
verilog/uspispy.sv
bench/psram_model.sv
bench/uspispy_tb.sv

// File: verilog/cmd_logger.sv
`timescale 1ns/1ns

module cmd_logger (
	input  logic                     clk,
	input  logic                     spi_cs_in,
	input  logic                     log_set,
	input  uspispy_pkg::spi_cmd_t    log_cmd_in,
	input  uspispy_pkg::flash_addr_t log_addr_in,
	output logic                     log_req,
	input  logic                     log_ack,
	output logic [7:0]               log_cmd,
	output logic [23:0]              log_addr
);

	typedef enum logic {lg_idle, lg_busy} lg_state_t;

	lg_state_t state;
	// record waiting for the controller to drop a stale ack
	logic      pend;

	always_ff @(posedge clk or posedge spi_cs_in) begin
		if (spi_cs_in) begin
			state <= lg_idle;
			pend  <= 1'b0;
		end else begin
			case (state)
				lg_idle: begin
					// four phase: never raise req over a high ack
					if ((log_set || pend) && !log_ack) begin
						state <= lg_busy;
						pend  <= 1'b0;
					end else if (log_set) begin
						pend <= 1'b1;
					end
				end
				default: begin
					if (log_ack)
						state <= lg_idle;
				end
			endcase
		end
	end

	// no queue, a newer record simply replaces the old one
	always_ff @(posedge clk) begin
		if (log_set) begin
			log_cmd  <= log_cmd_in;
			log_addr <= log_addr_in;
		end
	end

	assign log_req = (state == lg_busy);

endmodule

// File: verilog/page_buffer.sv
`timescale 1ns/1ns

module page_buffer #(
	parameter int page_abits = 8
) (
	input  logic                  clk,
	input  logic                  spi_cs_in,
	spi_frame_if.sink             frame,
	input  logic                  prog_en,
	input  logic [page_abits-1:0] buf_raddr,
	output logic [7:0]            buf_rdata
);

	logic [7:0]            mem [2**page_abits];
	// next slot to fill within this transaction
	logic [page_abits-1:0] wr_ptr;

	always_ff @(posedge clk or posedge spi_cs_in) begin
		if (spi_cs_in)
			wr_ptr <= '0;
		else if (prog_en && frame.byte_done)
			wr_ptr <= wr_ptr + page_abits'(1);
	end

	// data byte k lands at index k and wraps inside the page
	always_ff @(posedge clk) begin
		if (prog_en && frame.byte_done)
			mem[wr_ptr] <= frame.rx_byte;
	end

	// controller reads back asynchronously
	assign buf_rdata = mem[buf_raddr];

endmodule

// File: verilog/psram_router.sv
`timescale 1ns/1ns

module psram_router (
	input  logic                     spi_cs_in,
	input  logic                     ram_keep,
	input  logic                     read_route,
	input  uspispy_pkg::flash_addr_t read_addr,
	input  logic                     mosi,
	input  logic                     fpga_miso,
	input  logic                     ram0_miso,
	input  logic                     ram1_miso,
	output logic                     ram0_cs,
	output logic                     ram1_cs,
	output logic                     ram_mosi,
	output logic                     miso
);

	// active low selects
	// both chips follow the host until the command turns out not to be a read
	assign ram0_cs = spi_cs_in | ~ram_keep;
	assign ram1_cs = spi_cs_in | ~ram_keep;

	// host data goes to both chips unchanged
	assign ram_mosi = mosi;

	// top address bit picks the chip, no register in the data path
	always_comb begin
		if (!read_route)
			miso = fpga_miso;
		else if (read_addr[23])
			miso = ram1_miso;
		else
			miso = ram0_miso;
	end

endmodule

// File: verilog/spi_byte_counter.sv
`timescale 1ns/1ns

module spi_byte_counter (
	input  logic          clk,
	input  logic          spi_cs_in,
	spi_frame_if.counter  frame
);

	// position within the current byte
	logic [2:0] bit_cnt;

	// last bit of a byte is being sampled
	assign frame.byte_done = (bit_cnt == 3'd7);

	always_ff @(posedge clk or posedge spi_cs_in) begin
		if (spi_cs_in) begin
			bit_cnt        <= 3'd0;
			frame.byte_idx <= 8'd0;
		end else begin
			// wraps naturally every eight edges
			bit_cnt <= bit_cnt + 3'd1;
			// saturate, long reads just keep streaming
			if (frame.byte_done && frame.byte_idx != 8'hFF)
				frame.byte_idx <= frame.byte_idx + 8'd1;
		end
	end

endmodule

// File: verilog/spi_cmd_fsm.sv
`timescale 1ns/1ns

module spi_cmd_fsm (
	input  logic                    clk,
	input  logic                    spi_cs_in,
	spi_frame_if.sink               frame,
	input  logic [7:0]              sr_in,
	output logic [7:0]              tx_byte,
	output logic                    tx_load,
	output logic                    read_route,
	output uspispy_pkg::flash_addr_t read_addr,
	output logic                    ram_keep,
	output logic                    prog_en,
	output uspispy_pkg::spi_cmd_t   log_cmd,
	output uspispy_pkg::flash_addr_t log_addr,
	output logic                    log_set
);

	uspispy_pkg::spi_state_t  state;
	uspispy_pkg::spi_cmd_t    cmd;
	uspispy_pkg::flash_addr_t addr;
	// wel as seen while the command byte came in
	logic                     wel;

	// command and address are payload, captured on byte boundaries
	always_ff @(posedge clk) begin
		if (frame.byte_done) begin
			if (state == uspispy_pkg::st_cmd)
				cmd <= uspispy_pkg::spi_cmd_t'(frame.rx_byte);
			if (state == uspispy_pkg::st_addr) begin
				case (frame.byte_idx)
					8'd1:    addr[23:16] <= frame.rx_byte;
					8'd2:    addr[15:8]  <= frame.rx_byte;
					default: addr[7:0]   <= frame.rx_byte;
				endcase
			end
		end
	end

	always_ff @(posedge clk or posedge spi_cs_in) begin
		if (spi_cs_in) begin
			state      <= uspispy_pkg::st_cmd;
			wel        <= 1'b0;
			read_route <= 1'b0;
			// both psrams see every command byte
			ram_keep   <= 1'b1;
			prog_en    <= 1'b0;
			log_set    <= 1'b0;
		end else begin
			log_set <= 1'b0;
			if (frame.byte_done) begin
				case (state)
					uspispy_pkg::st_cmd: begin
						wel      <= sr_in[uspispy_pkg::sr_wel_bit];
						// only reads keep the psrams selected
						ram_keep <= (frame.rx_byte == uspispy_pkg::cmd_read);
						case (frame.rx_byte)
							uspispy_pkg::cmd_rdid,
							uspispy_pkg::cmd_rdsr:  state <= uspispy_pkg::st_reply;
							uspispy_pkg::cmd_read,
							uspispy_pkg::cmd_pp,
							uspispy_pkg::cmd_erase: state <= uspispy_pkg::st_addr;
							uspispy_pkg::cmd_wren,
							uspispy_pkg::cmd_wrds: begin
								// controller tracks wel, tell it now
								log_set <= 1'b1;
								state   <= uspispy_pkg::st_ignore;
							end
							default:                state <= uspispy_pkg::st_ignore;
						endcase
					end
					uspispy_pkg::st_addr: begin
						if (frame.byte_idx == 8'd3) begin
							log_set <= 1'b1;
							case (cmd)
								uspispy_pkg::cmd_read: begin
									state      <= uspispy_pkg::st_read;
									read_route <= 1'b1;
								end
								uspispy_pkg::cmd_pp: begin
									state   <= uspispy_pkg::st_prog;
									// program without wel is logged but not buffered
									prog_en <= wel;
								end
								default: state <= uspispy_pkg::st_ignore;
							endcase
						end
					end
					// reply, read, prog and ignore run to chip select
					default: state <= state;
				endcase
			end
		end
	end

	// response byte must be loaded on the very edge the host byte completes
	always_comb begin
		tx_load = 1'b0;
		tx_byte = 8'h00;
		if (frame.byte_done) begin
			if (state == uspispy_pkg::st_cmd) begin
				if (frame.rx_byte == uspispy_pkg::cmd_rdid) begin
					tx_load = 1'b1;
					tx_byte = uspispy_pkg::flash_id[23:16];
				end else if (frame.rx_byte == uspispy_pkg::cmd_rdsr) begin
					tx_load = 1'b1;
					tx_byte = sr_in;
				end
			end else if (state == uspispy_pkg::st_reply) begin
				tx_load = 1'b1;
				// status repeats, id runs out to zeros
				if (cmd == uspispy_pkg::cmd_rdsr)
					tx_byte = sr_in;
				else if (frame.byte_idx == 8'd1)
					tx_byte = uspispy_pkg::flash_id[15:8];
				else if (frame.byte_idx == 8'd2)
					tx_byte = uspispy_pkg::flash_id[7:0];
			end
		end
	end

	// router only needs bit 23, the psram tracks its own address
	assign read_addr = addr;
	assign log_cmd   = cmd;
	assign log_addr  = addr;

endmodule

// File: verilog/spi_frame_if.sv
`timescale 1ns/1ns

interface spi_frame_if;

	// last byte received from the host, msb first
	logic [7:0] rx_byte;
	// high for the edge that samples bit 8 of a byte
	logic       byte_done;
	// completed bytes so far, command byte is 0
	logic [7:0] byte_idx;

	// shifter builds the byte, it needs the done strobe to hold it
	modport shifter (output rx_byte, input byte_done);

	// counter owns the framing
	modport counter (output byte_done, byte_idx);

	// consumers only look
	modport sink (input rx_byte, byte_done, byte_idx);

endinterface

// File: verilog/spi_shifter.sv
`timescale 1ns/1ns

module spi_shifter (
	input  logic                clk,
	input  logic                spi_cs_in,
	input  logic                mosi,
	output logic                miso,
	input  logic [7:0]          tx_byte,
	input  logic                tx_load,
	spi_frame_if.shifter        frame
);

	// first seven bits of the byte in flight
	logic [6:0] rx_sr;
	// copy of the last complete byte
	logic [7:0] rx_hold;
	// response byte being shifted out
	logic [7:0] tx_sr;

	// the eighth bit is still on mosi when byte_done is high,
	// so the full byte is assembled combinationally on that edge
	assign frame.rx_byte = frame.byte_done ? {rx_sr, mosi} : rx_hold;

	always_ff @(posedge clk or posedge spi_cs_in) begin
		if (spi_cs_in) begin
			rx_sr <= 7'd0;
			tx_sr <= 8'd0;
		end else begin
			rx_sr <= {rx_sr[5:0], mosi};
			// load wins over shift so bit 7 shows right after the load edge
			if (tx_load)
				tx_sr <= tx_byte;
			else
				tx_sr <= {tx_sr[6:0], 1'b0};
		end
	end

	// hold the byte until the next one completes
	always_ff @(posedge clk) begin
		if (frame.byte_done)
			rx_hold <= {rx_sr, mosi};
	end

	// msb first, idles at 0 once the byte is out
	assign miso = tx_sr[7];

endmodule

// File: verilog/uspispy.sv
`timescale 1ns/1ns

module uspispy #(
	parameter int page_abits = 8
) (
	input  logic                  clk,
	input  logic                  spi_cs_in,
	input  logic                  mosi,
	output logic                  miso,
	input  logic [7:0]            sr_in,
	output logic                  ram0_cs,
	output logic                  ram1_cs,
	output logic                  ram_mosi,
	input  logic                  ram0_miso,
	input  logic                  ram1_miso,
	output logic                  log_req,
	input  logic                  log_ack,
	output logic [7:0]            log_cmd,
	output logic [23:0]           log_addr,
	input  logic [page_abits-1:0] buf_raddr,
	output logic [7:0]            buf_rdata
);

	// byte framing shared by the receive side
	spi_frame_if frame ();

	logic [7:0]               tx_byte;
	logic                     tx_load;
	logic                     fpga_miso;
	logic                     read_route;
	uspispy_pkg::flash_addr_t read_addr;
	logic                     ram_keep;
	logic                     prog_en;
	// record as the fsm sees it, before the logger latches it
	uspispy_pkg::spi_cmd_t    fsm_log_cmd;
	uspispy_pkg::flash_addr_t fsm_log_addr;
	logic                     log_set;

	spi_shifter u_shifter (
		.clk       (clk),
		.spi_cs_in (spi_cs_in),
		.mosi      (mosi),
		.miso      (fpga_miso),
		.tx_byte   (tx_byte),
		.tx_load   (tx_load),
		.frame     (frame.shifter)
	);

	spi_byte_counter u_counter (
		.clk       (clk),
		.spi_cs_in (spi_cs_in),
		.frame     (frame.counter)
	);

	spi_cmd_fsm u_fsm (
		.clk        (clk),
		.spi_cs_in  (spi_cs_in),
		.frame      (frame.sink),
		.sr_in      (sr_in),
		.tx_byte    (tx_byte),
		.tx_load    (tx_load),
		.read_route (read_route),
		.read_addr  (read_addr),
		.ram_keep   (ram_keep),
		.prog_en    (prog_en),
		.log_cmd    (fsm_log_cmd),
		.log_addr   (fsm_log_addr),
		.log_set    (log_set)
	);

	page_buffer #(
		.page_abits (page_abits)
	) u_page_buffer (
		.clk       (clk),
		.spi_cs_in (spi_cs_in),
		.frame     (frame.sink),
		.prog_en   (prog_en),
		.buf_raddr (buf_raddr),
		.buf_rdata (buf_rdata)
	);

	cmd_logger u_logger (
		.clk         (clk),
		.spi_cs_in   (spi_cs_in),
		.log_set     (log_set),
		.log_cmd_in  (fsm_log_cmd),
		.log_addr_in (fsm_log_addr),
		.log_req     (log_req),
		.log_ack     (log_ack),
		.log_cmd     (log_cmd),
		.log_addr    (log_addr)
	);

	psram_router u_router (
		.spi_cs_in  (spi_cs_in),
		.ram_keep   (ram_keep),
		.read_route (read_route),
		.read_addr  (read_addr),
		.mosi       (mosi),
		.fpga_miso  (fpga_miso),
		.ram0_miso  (ram0_miso),
		.ram1_miso  (ram1_miso),
		.ram0_cs    (ram0_cs),
		.ram1_cs    (ram1_cs),
		.ram_mosi   (ram_mosi),
		.miso       (miso)
	);

endmodule

// File: verilog/uspispy_pkg.sv
package uspispy_pkg;

	// command codes understood by the flash front end
	// anything else is ignored for the rest of the transaction
	typedef enum logic [7:0] {
		cmd_read  = 8'h03,
		cmd_pp    = 8'h02,
		cmd_erase = 8'h20,
		cmd_wren  = 8'h06,
		cmd_wrds  = 8'h04,
		cmd_rdsr  = 8'h05,
		cmd_rdid  = 8'h9F
	} spi_cmd_t;

	// command fsm states, one transaction per chip select pulse
	typedef enum logic [2:0] {
		st_cmd,
		st_addr,
		st_reply,
		st_read,
		st_prog,
		st_ignore
	} spi_state_t;

	// three byte flash address, msb first on the wire
	typedef logic [23:0] flash_addr_t;

	// jedec id: manufacturer, memory type, capacity
	localparam logic [23:0] flash_id = 24'hC22018;

	// write-enable latch position in the status byte
	localparam int sr_wel_bit = 1;

endpackage
